// ==== lsu_sub.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_store_align.sv
hw/lsu_data_ram.sv
hw/lsu_load_extract.sv
hw/lsu_top.sv
tb/lsu_checker.sv
tb/tb_lsu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lsu testbench with verilator
verilator --binary --timing --assert -Wno-fatal -f lsu_sub.f --top-module tb_lsu_top \
    --Mdir obj_dir -o sim_lsu > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_lsu > sim.log 2>&1
grep -q "Simulation finished: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"

// ==== tb/tb_lsu_top.sv ====
// lsu testbench top
`timescale 1ns/100ps

`include "lsu_cfg.svh"

module tb_lsu_top;

    localparam int FILL_OPS    = 64;
    localparam int FIXED_OPS   = 27;
    localparam int RAND_OPS    = 400;
    // each request waits, is accepted, and may get one idle cycle after it.
    localparam int CYCLE_LIMIT = (FILL_OPS + FIXED_OPS + RAND_OPS) * (`LSU_RAM_WAIT + 2) + 100;

    logic             clk;
    logic             arst_n;
    logic             start;
    lsu_pkg::lsu_op_e op;
    lsu_pkg::addr_t   addr;
    lsu_pkg::word_t   wdata;
    logic             done;
    lsu_pkg::word_t   result;
    logic             result_valid;
    logic             misaligned;
    logic [31:0]      rnd;
    int               cycles;
    int               value_errs;
    int               timing_errs;
    int               flag_errs;
    int               loads_seen;

    lsu_top i_lsu_top (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .start_i        (start),
        .op_i           (op),
        .addr_i         (addr),
        .wdata_i        (wdata),
        .done_o         (done),
        .result_o       (result),
        .result_valid_o (result_valid),
        .misaligned_o   (misaligned)
    );

    lsu_checker u_checker (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .start_i        (start),
        .op_i           (op),
        .addr_i         (addr),
        .wdata_i        (wdata),
        .done_i         (done),
        .result_i       (result),
        .result_valid_i (result_valid),
        .misaligned_i   (misaligned),
        .value_errs_o   (value_errs),
        .timing_errs_o  (timing_errs),
        .flag_errs_o    (flag_errs),
        .loads_seen_o   (loads_seen)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // --------------------
    // request driver
    // --------------------
    task automatic issue(input lsu_pkg::lsu_op_e req_op, input lsu_pkg::addr_t req_addr,
                         input lsu_pkg::word_t req_data);
        start <= 1'b1;
        op    <= req_op;
        addr  <= req_addr;
        wdata <= req_data;
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
        @(posedge clk);  // accepted on this edge.
        start <= 1'b0;
    endtask

    task automatic run_fixed();
        for (int i = 0; i < 4; i++) begin
            issue(lsu_pkg::LSU_LW, lsu_pkg::addr_t'(i * 4), '0);
        end
        issue(lsu_pkg::LSU_SW, 32'h14, 32'h8a7f_f501);  // both sign cases in one word.
        for (int i = 0; i < 4; i++) begin
            issue(lsu_pkg::LSU_LB, lsu_pkg::addr_t'(32'h14 + i), '0);
            issue(lsu_pkg::LSU_LBU, lsu_pkg::addr_t'(32'h14 + i), '0);
        end
        for (int i = 0; i < 4; i += 2) begin
            issue(lsu_pkg::LSU_LH, lsu_pkg::addr_t'(32'h14 + i), '0);
            issue(lsu_pkg::LSU_LHU, lsu_pkg::addr_t'(32'h14 + i), '0);
        end
        issue(lsu_pkg::LSU_SB, 32'h1a, 32'h1122_33c3);
        issue(lsu_pkg::LSU_LW, 32'h18, '0);
        issue(lsu_pkg::LSU_SH, 32'h1e, 32'h5566_9abc);
        issue(lsu_pkg::LSU_LW, 32'h1c, '0);
        // misaligned requests, then word 0x28 must read back untouched.
        issue(lsu_pkg::LSU_LW, 32'h21, '0);
        issue(lsu_pkg::LSU_LW, 32'h22, '0);
        issue(lsu_pkg::LSU_LH, 32'h23, '0);
        issue(lsu_pkg::LSU_LHU, 32'h25, '0);
        issue(lsu_pkg::LSU_SH, 32'h29, 32'hdead_beef);
        issue(lsu_pkg::LSU_LW, 32'h28, '0);
    endtask

    task automatic run_random();
        lsu_pkg::lsu_op_e r_op;
        lsu_pkg::addr_t   r_addr;
        logic             idle;
        for (int n = 0; n < RAND_OPS; n++) begin
            rnd    = xorshift(rnd);
            r_op   = lsu_pkg::lsu_op_e'(rnd[2:0]);
            r_addr = {24'h0, rnd[13:8], rnd[17:16]};  // 64-word window.
            idle   = (rnd[21:20] == 2'b00);
            if (r_op == lsu_pkg::LSU_SW) begin
                r_addr[1:0] = 2'b00;
            end
            rnd = xorshift(rnd);
            issue(r_op, r_addr, rnd);
            if (idle) begin
                @(posedge clk);
            end
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        arst_n = 1'b0;
        start  = 1'b0;
        op     = lsu_pkg::LSU_LW;
        addr   = '0;
        wdata  = '0;
        rnd    = 32'h352f_1dae;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < FILL_OPS; i++) begin
            issue(lsu_pkg::LSU_SW, lsu_pkg::addr_t'(i * 4),
                  (lsu_pkg::word_t'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f);
        end
        run_fixed();
        run_random();
        repeat (3) @(posedge clk);
        @(negedge clk);  // counters settle between edges.
        $display("errors: value %0d, timing %0d, flag %0d; loads checked %0d",
                 value_errs, timing_errs, flag_errs, loads_seen);
        if (value_errs + timing_errs + flag_errs == 0 && loads_seen > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run hung after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

// ==== tb/lsu_checker.sv ====
// load store checker
`timescale 1ns/100ps

`include "lsu_cfg.svh"

module lsu_checker (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             start_i,
    input  lsu_pkg::lsu_op_e op_i,
    input  lsu_pkg::addr_t   addr_i,
    input  lsu_pkg::word_t   wdata_i,
    input  logic             done_i,
    input  lsu_pkg::word_t   result_i,
    input  logic             result_valid_i,
    input  logic             misaligned_i,
    output int               value_errs_o,
    output int               timing_errs_o,
    output int               flag_errs_o,
    output int               loads_seen_o
);

    lsu_pkg::word_t           shadow [0:`LSU_RAM_WORDS-1];
    int                       wait_cnt;
    int                       exp_wait;
    logic                     exp_mis;
    logic                     pending;
    lsu_pkg::word_t           exp_result;
    lsu_pkg::lsu_op_e         pend_op;
    lsu_pkg::addr_t           pend_addr;
    logic [`LSU_IDX_BITS-1:0] idx;

    // --------------------
    // reference model
    // --------------------
    function automatic logic misaligned_ref(lsu_pkg::lsu_op_e req_op, lsu_pkg::addr_t req_addr);
        if (req_op == lsu_pkg::LSU_LW) begin
            return req_addr[1:0] != 2'b00;
        end
        if (req_op inside {lsu_pkg::LSU_LH, lsu_pkg::LSU_LHU, lsu_pkg::LSU_SH}) begin
            return req_addr[0];
        end
        return 1'b0;
    endfunction

    function automatic lsu_pkg::word_t load_ref(lsu_pkg::word_t word, lsu_pkg::lsu_op_e req_op,
                                                logic [1:0] lane);
        lsu_pkg::word_t shifted;
        shifted = word >> {lane, 3'b000};  // addressed lane moves to the bottom.
        case (req_op)
            lsu_pkg::LSU_LB:  return {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::LSU_LBU: return {24'h0, shifted[7:0]};
            lsu_pkg::LSU_LH:  return {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::LSU_LHU: return {16'h0, shifted[15:0]};
            default:          return word;
        endcase
    endfunction

    function automatic lsu_pkg::word_t store_ref(lsu_pkg::word_t old, lsu_pkg::lsu_op_e req_op,
                                                 logic [1:0] lane, lsu_pkg::word_t data);
        lsu_pkg::word_t keep;
        lsu_pkg::word_t put;
        keep = 32'h0;
        put  = data;
        if (req_op == lsu_pkg::LSU_SB) begin
            keep = ~(32'h0000_00ff << {lane, 3'b000});
            put  = {24'h0, data[7:0]} << {lane, 3'b000};
        end else if (req_op == lsu_pkg::LSU_SH) begin
            keep = ~(32'h0000_ffff << {lane, 3'b000});
            put  = {16'h0, data[15:0]} << {lane, 3'b000};
        end
        return (old & keep) | put;
    endfunction

    // --------------------
    // comparison
    // --------------------
    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            wait_cnt      = 0;
            pending       = 1'b0;
            value_errs_o  = 0;
            timing_errs_o = 0;
            flag_errs_o   = 0;
            loads_seen_o  = 0;
        end else begin
            if (pending && result_valid_i !== 1'b1) begin
                timing_errs_o++;
                $display("result_valid_o missing one cycle after %s at %h",
                         pend_op.name(), pend_addr);
            end else if (pending && result_i !== exp_result) begin
                value_errs_o++;
                $display("ERROR %s at %h: expected %h, actual %h",
                         pend_op.name(), pend_addr, exp_result, result_i);
            end else if (!pending && result_valid_i !== 1'b0) begin
                timing_errs_o++;
                $display("result_valid_o went high without an accepted load");
            end
            if (pending) begin
                loads_seen_o++;
            end
            pending = 1'b0;
            if (!start_i && done_i !== 1'b1) begin
                timing_errs_o++;
                $display("done_o is low although no request is pending");
            end
            if (start_i) begin
                exp_mis = misaligned_ref(op_i, addr_i);
                if (misaligned_i !== exp_mis) begin
                    flag_errs_o++;
                    $display("ERROR misaligned flag %s at %h: expected %b, actual %b",
                             op_i.name(), addr_i, exp_mis, misaligned_i);
                end
                if (done_i !== 1'b1) begin
                    wait_cnt++;
                end else begin
                    exp_wait = exp_mis ? 0 : `LSU_RAM_WAIT;  // misaligned never waits.
                    if (wait_cnt != exp_wait) begin
                        timing_errs_o++;
                        $display("ERROR done latency %s at %h: expected %0d, actual %0d",
                                 op_i.name(), addr_i, exp_wait, wait_cnt);
                    end
                    wait_cnt = 0;
                    idx      = addr_i[`LSU_IDX_BITS+1:2];
                    if (!exp_mis && op_i inside {lsu_pkg::LSU_SB, lsu_pkg::LSU_SH,
                                                 lsu_pkg::LSU_SW}) begin
                        shadow[idx] = store_ref(shadow[idx], op_i, addr_i[1:0], wdata_i);
                    end else if (!exp_mis) begin
                        pending    = 1'b1;  // result due on the next edge.
                        exp_result = load_ref(shadow[idx], op_i, addr_i[1:0]);
                        pend_op    = op_i;
                        pend_addr  = addr_i;
                    end
                end
            end
        end
    end

endmodule

// ==== hw/lsu_top.sv ====
// load store unit top
`timescale 1ns/100ps

`include "lsu_cfg.svh"

module lsu_top (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             start_i,
    input  lsu_pkg::lsu_op_e op_i,
    input  lsu_pkg::addr_t   addr_i,
    input  lsu_pkg::word_t   wdata_i,
    output logic             done_o,
    output lsu_pkg::word_t   result_o,
    output logic             result_valid_o,
    output logic             misaligned_o
);

    logic                      mem_sel;
    logic                      mem_we;
    logic [`LSU_IDX_BITS-1:0]  mem_idx;
    lsu_pkg::mask_t            mem_mask;
    lsu_pkg::word_t            mem_wdata;
    lsu_pkg::word_t            mem_rdata;
    logic                      mem_stall;
    logic                      load_take;

    // --------------------
    // handshake
    // --------------------
    assign done_o    = start_i ? !mem_stall : 1'b1;
    assign load_take = start_i && done_o && mem_sel && !lsu_pkg::is_store(op_i);

    lsu_store_align u_align (
        .op_i         (op_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .start_i      (start_i),
        .mem_sel_o    (mem_sel),
        .mem_we_o     (mem_we),
        .mem_idx_o    (mem_idx),
        .mem_mask_o   (mem_mask),
        .mem_wdata_o  (mem_wdata),
        .misaligned_o (misaligned_o)  // never stalled, so it marks acceptance.
    );

    lsu_data_ram u_ram (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .sel_i    (mem_sel),
        .we_i     (mem_we),
        .idx_i    (mem_idx),
        .mask_i   (mem_mask),
        .wdata_i  (mem_wdata),
        .rdata_o  (mem_rdata),
        .stall_o  (mem_stall)
    );

    lsu_load_extract u_extract (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .take_i         (load_take),
        .op_i           (op_i),
        .lane_i         (addr_i[1:0]),
        .rdata_i        (mem_rdata),
        .result_o       (result_o),
        .result_valid_o (result_valid_o)
    );

    // request must hold until it is accepted.
    a_req_hold : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (start_i && !done_o) |=> (start_i && $stable(op_i) && $stable(addr_i))
    ) else $error("lsu_top: request changed before done");

endmodule

// ==== hw/lsu_load_extract.sv ====
// load extract stage
`timescale 1ns/100ps

module lsu_load_extract (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             take_i,
    input  lsu_pkg::lsu_op_e op_i,
    input  logic [1:0]       lane_i,
    input  lsu_pkg::word_t   rdata_i,
    output lsu_pkg::word_t   result_o,
    output logic             result_valid_o
);

    lsu_pkg::lsu_op_e op_q;
    logic [1:0]       lane_q;
    logic [7:0]       byte_sel;
    logic [15:0]      half_sel;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= take_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_i) begin
            op_q   <= op_i;
            lane_q <= lane_i;
        end
    end

    // --------------------
    // extraction
    // --------------------
    assign byte_sel = rdata_i[8*lane_q +: 8];
    assign half_sel = lane_q[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (op_q)
            lsu_pkg::LSU_LB:  result_o = {{24{byte_sel[7]}}, byte_sel};
            lsu_pkg::LSU_LBU: result_o = {24'h0, byte_sel};
            lsu_pkg::LSU_LH:  result_o = {{16{half_sel[15]}}, half_sel};
            lsu_pkg::LSU_LHU: result_o = {16'h0, half_sel};
            default:          result_o = rdata_i;  // lw.
        endcase
    end

    // only loads may enter the extract stage.
    a_take_is_load : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        take_i |-> !lsu_pkg::is_store(op_i)
    ) else $error("lsu_load_extract: take asserted for a store operation");

endmodule

// ==== hw/lsu_data_ram.sv ====
// data memory stage
`timescale 1ns/100ps

`include "lsu_cfg.svh"

module lsu_data_ram (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      sel_i,
    input  logic                      we_i,
    input  logic [`LSU_IDX_BITS-1:0]  idx_i,
    input  lsu_pkg::mask_t            mask_i,
    input  lsu_pkg::word_t            wdata_i,
    output lsu_pkg::word_t            rdata_o,
    output logic                      stall_o
);

    localparam int CNT_W = (`LSU_RAM_WAIT > 0) ? $clog2(`LSU_RAM_WAIT + 1) : 1;

    lsu_pkg::word_t   mem [0:`LSU_RAM_WORDS-1];
    logic [CNT_W-1:0] wait_cnt;
    logic             wait_done;
    logic             access;

    // --------------------
    // wait states
    // --------------------
    assign wait_done = (wait_cnt == CNT_W'(`LSU_RAM_WAIT));
    assign access    = sel_i && wait_done;
    assign stall_o   = sel_i && !wait_done;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_cnt <= '0;
        end else if (!sel_i || access) begin
            wait_cnt <= '0;  // idle or finished access.
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // --------------------
    // storage
    // --------------------
    always_ff @(posedge clk_i) begin
        if (access) begin
            for (int i = 0; i < 4; i++) begin
                if (we_i && mask_i[i]) begin
                    mem[idx_i][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
            rdata_o <= mem[idx_i];  // old word on a store.
        end
    end

    // the index may not move while the access waits.
    a_idx_stable : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (sel_i && stall_o) |=> $stable(idx_i)
    ) else $error("lsu_data_ram: index changed during wait states");

endmodule

// ==== hw/lsu_store_align.sv ====
// store align stage
`timescale 1ns/100ps

`include "lsu_cfg.svh"

module lsu_store_align (
    input  lsu_pkg::lsu_op_e          op_i,
    input  lsu_pkg::addr_t            addr_i,
    input  lsu_pkg::word_t            wdata_i,
    input  logic                      start_i,
    output logic                      mem_sel_o,
    output logic                      mem_we_o,
    output logic [`LSU_IDX_BITS-1:0]  mem_idx_o,
    output lsu_pkg::mask_t            mem_mask_o,
    output lsu_pkg::word_t            mem_wdata_o,
    output logic                      misaligned_o
);

    logic bad_align;

    // --------------------
    // alignment check
    // --------------------
    always_comb begin
        case (op_i)
            lsu_pkg::LSU_LW:  bad_align = (addr_i[1:0] != 2'b00);
            lsu_pkg::LSU_LH,
            lsu_pkg::LSU_LHU,
            lsu_pkg::LSU_SH:  bad_align = addr_i[0];
            default:          bad_align = 1'b0;  // byte ops, sw drops the low bits.
        endcase
    end

    assign misaligned_o = start_i && bad_align;
    assign mem_sel_o    = start_i && !bad_align;
    assign mem_we_o     = mem_sel_o && lsu_pkg::is_store(op_i);
    assign mem_idx_o    = addr_i[`LSU_IDX_BITS+1:2];

    // --------------------
    // lane mask and data
    // --------------------
    always_comb begin
        case (op_i)
            lsu_pkg::LSU_SB: begin
                mem_mask_o  = 4'b0001 << addr_i[1:0];
                mem_wdata_o = {4{wdata_i[7:0]}};   // byte copied into every lane.
            end
            lsu_pkg::LSU_SH: begin
                mem_mask_o  = addr_i[1] ? 4'b1100 : 4'b0011;
                mem_wdata_o = {2{wdata_i[15:0]}};  // half copied into both halves.
            end
            default: begin
                mem_mask_o  = 4'b1111;  // loads and sw use the whole word.
                mem_wdata_o = wdata_i;
            end
        endcase
    end

endmodule

// ==== hw/lsu_pkg.sv ====
// lsu shared types
package lsu_pkg;

    typedef logic [31:0] word_t;  // data word.
    typedef logic [31:0] addr_t;  // byte address.
    typedef logic [3:0]  mask_t;  // one bit per byte lane.

    // --------------------
    // memory operations
    // --------------------
    typedef enum logic [2:0] {
        LSU_LB  = 3'd0,
        LSU_LH  = 3'd1,
        LSU_LW  = 3'd2,
        LSU_LBU = 3'd3,
        LSU_LHU = 3'd4,
        LSU_SB  = 3'd5,
        LSU_SH  = 3'd6,
        LSU_SW  = 3'd7
    } lsu_op_e;

    // true for operations that write memory.
    function automatic logic is_store(lsu_op_e op);
        return (op == LSU_SB) || (op == LSU_SH) || (op == LSU_SW);
    endfunction

endpackage

// ==== hw/lsu_cfg.svh ====
// lsu configuration
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// --------------------
// data memory
// --------------------

// depth of the data ram in 32-bit words.
`define LSU_RAM_WORDS 256

// stall cycles before each access, 0 allowed.
`define LSU_RAM_WAIT 2

// width of the word index into the ram.
`define LSU_IDX_BITS 8

`endif
